/* rtl/bram_pkg.sv */
// shared map and types for the block RAM pipeline; only the 64 KB window at address 0 is backed
package bram_pkg;

   // requester tag, with one extra id bit above it for IO traffic
   localparam int TAG_WIDTH = 5;
   localparam int ID_IO_BIT = TAG_WIDTH;        // set for IO-sourced requests

   localparam int ADDR_WIDTH      = 32;
   localparam int LINE_DATA_WIDTH = 128;
   localparam int LINE_STRB_WIDTH = LINE_DATA_WIDTH / 8;

   // block RAM geometry
   localparam int BRAM_ADDR_WIDTH = 16;         // 64 KB
   localparam int LINE_OFFSET     = $clog2(LINE_STRB_WIDTH);
   localparam int BRAM_LINES      = (2 ** BRAM_ADDR_WIDTH) / LINE_STRB_WIDTH;
   localparam int LINE_IDX_WIDTH  = $clog2(BRAM_LINES);

   typedef logic [ID_IO_BIT:0]           id_t;
   typedef logic [ADDR_WIDTH-1:0]        addr_t;
   typedef logic [LINE_DATA_WIDTH-1:0]   line_data_t;
   typedef logic [LINE_STRB_WIDTH-1:0]   line_strb_t;
   typedef logic [LINE_IDX_WIDTH-1:0]    line_idx_t;

   // block RAM window, mask bits are don't-care in the compare
   localparam addr_t BRAM_BASE = 32'h0000_0000;
   localparam addr_t BRAM_MASK = 32'h0000_ffff;

   // request as it arrives at the top
   typedef struct packed {
      logic       we;
      id_t        id;
      addr_t      addr;
      line_data_t wdata;
      line_strb_t strb;
   } mem_req_t;

   // request after the window decode
   typedef struct packed {
      logic       valid;
      logic       hit;          // inside the block RAM window
      logic       we;
      id_t        id;
      line_idx_t  line;
      line_data_t wdata;
      line_strb_t strb;
   } decoded_req_t;

   // response leaving the last stage
   typedef struct packed {
      logic       we;
      id_t        id;
      logic       err;          // address outside the window
      line_data_t rdata;
   } mem_resp_t;

   // address agrees with base on every bit that the mask leaves out
   function automatic logic addr_in_window(
      input addr_t addr,
      input addr_t base,
      input addr_t mask
   );
      addr_t diff;
      diff = (addr ^ base) & ~mask;
      return (diff == '0);
   endfunction

   // line index sits just above the byte offset
   function automatic line_idx_t addr_to_line(input addr_t addr);
      return addr[BRAM_ADDR_WIDTH-1:LINE_OFFSET];
   endfunction

endpackage

/* rtl/mem_region_decode.sv */
// first stage; a new request may come every cycle and any address outside 0x0000_0000 to 0x0000_ffff is flagged as a miss
`timescale 1ns/1ps

module mem_region_decode (
   input  logic                  mig_clk,
   input  logic                  rst_n_i,
   input  logic                  req_valid_i,
   input  bram_pkg::mem_req_t    req_i,
   output bram_pkg::decoded_req_t dec_o
);

   import bram_pkg::*;

   logic      hit_d;
   line_idx_t line_d;
   logic      valid_q;
   logic      hit_q;
   logic      we_q;
   id_t       id_q;
   line_idx_t line_q;
   line_data_t wdata_q;
   line_strb_t strb_q;

   // window compare on the incoming address
   always_comb begin
      hit_d  = addr_in_window(req_i.addr, BRAM_BASE, BRAM_MASK);
      line_d = addr_to_line(req_i.addr);
   end

   always_ff @(posedge mig_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= req_valid_i;
      end
   end

   // payload only follows a valid strobe
   always_ff @(posedge mig_clk) begin
      if (req_valid_i) begin
         hit_q   <= hit_d;
         we_q    <= req_i.we;
         id_q    <= req_i.id;
         line_q  <= line_d;
         wdata_q <= req_i.wdata;
         strb_q  <= req_i.strb;
      end
   end

   always_comb begin
      dec_o.valid = valid_q;
      dec_o.hit   = hit_q;
      dec_o.we    = we_q;
      dec_o.id    = id_q;
      dec_o.line  = line_q;
      dec_o.wdata = wdata_q;
      dec_o.strb  = strb_q;
   end

endmodule

/* rtl/bram_line_store.sv */
// second stage with 4096 lines of 128 bits; contents are undefined until written and there is no init image
`timescale 1ns/1ps

module bram_line_store (
   input  logic                   mig_clk,
   input  logic                   rst_n_i,
   input  bram_pkg::decoded_req_t dec_i,
   output bram_pkg::decoded_req_t stage_o,
   output bram_pkg::line_data_t   rd_data_o
);

   import bram_pkg::*;

   line_data_t   mem_q [BRAM_LINES];
   line_idx_t    rd_line_q;
   logic         access;
   logic         wr_en;
   logic         stage_valid_q;
   decoded_req_t stage_q;

   assign access = dec_i.valid && dec_i.hit;
   assign wr_en  = access && dec_i.we;

   // byte lanes written under their strobe
   always_ff @(posedge mig_clk) begin
      if (wr_en) begin
         for (int b = 0; b < LINE_STRB_WIDTH; b++) begin
            if (dec_i.strb[b]) begin
               mem_q[dec_i.line][b*8 +: 8] <= dec_i.wdata[b*8 +: 8];
            end
         end
      end
   end

   // read address held for the array read
   always_ff @(posedge mig_clk) begin
      if (access) begin
         rd_line_q <= dec_i.line;
      end
   end

   // array read after the write edge, so a write shows on the next read
   assign rd_data_o = mem_q[rd_line_q];

   always_ff @(posedge mig_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stage_valid_q <= 1'b0;
      end else begin
         stage_valid_q <= dec_i.valid;
      end
   end

   // tag and control move along with the access
   always_ff @(posedge mig_clk) begin
      if (dec_i.valid) begin
         stage_q <= dec_i;
      end
   end

   always_comb begin
      stage_o       = stage_q;
      stage_o.valid = stage_valid_q;
   end

endmodule

/* rtl/mem_resp_stage.sv */
// last stage; writes and misses return zero data and a miss sets err with no other side effect
`timescale 1ns/1ps

module mem_resp_stage (
   input  logic                   mig_clk,
   input  logic                   rst_n_i,
   input  bram_pkg::decoded_req_t stage_i,
   input  bram_pkg::line_data_t   rd_data_i,
   output logic                   resp_valid_o,
   output bram_pkg::mem_resp_t    resp_o
);

   import bram_pkg::*;

   mem_resp_t resp_d;
   mem_resp_t resp_q;
   logic      valid_q;
   logic      hit_read;

   assign hit_read = stage_i.hit && !stage_i.we;

   always_comb begin
      resp_d.we    = stage_i.we;
      resp_d.id    = stage_i.id;       // io bit included
      resp_d.err   = !stage_i.hit;
      resp_d.rdata = hit_read ? rd_data_i : '0;
   end

   always_ff @(posedge mig_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= stage_i.valid;
      end
   end

   // response payload
   always_ff @(posedge mig_clk) begin
      if (stage_i.valid) begin
         resp_q <= resp_d;
      end
   end

   assign resp_valid_o = valid_q;
   assign resp_o       = resp_q;

endmodule

/* rtl/bram_subsys_top.sv */
// three clocks from request to response with no back-pressure, so a request is accepted every cycle
`timescale 1ns/1ps

module bram_subsys_top (
   input  logic                mig_clk,
   input  logic                rst_n_i,
   input  logic                req_valid_i,
   input  bram_pkg::mem_req_t  req_i,
   output logic                resp_valid_o,
   output bram_pkg::mem_resp_t resp_o
);

   import bram_pkg::*;

   decoded_req_t dec_req;
   decoded_req_t stage_req;
   line_data_t   rd_data;

   // address decode
   mem_region_decode u_decode (
      .mig_clk     ( mig_clk     ),
      .rst_n_i     ( rst_n_i     ),
      .req_valid_i ( req_valid_i ),
      .req_i       ( req_i       ),
      .dec_o       ( dec_req     )
   );

   // line memory
   bram_line_store u_store (
      .mig_clk   ( mig_clk   ),
      .rst_n_i   ( rst_n_i   ),
      .dec_i     ( dec_req   ),
      .stage_o   ( stage_req ),
      .rd_data_o ( rd_data   )
   );

   // response forming
   mem_resp_stage u_resp (
      .mig_clk      ( mig_clk      ),
      .rst_n_i      ( rst_n_i      ),
      .stage_i      ( stage_req    ),
      .rd_data_i    ( rd_data      ),
      .resp_valid_o ( resp_valid_o ),
      .resp_o       ( resp_o       )
   );

endmodule

/* verif/tb_clock_gen.sv */
// free-running 100 ns clock; reset is held low for four rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
   output logic mig_clk,
   output logic rst_n_o
);

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 4;

   initial begin
      mig_clk = 1'b0;
      forever #(HALF_PERIOD) mig_clk = ~mig_clk;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge mig_clk);
      @(negedge mig_clk);   // release away from the sampling edge
      rst_n_o = 1'b1;
   end

endmodule

/* verif/bram_subsys_assertions.sv */
// bound into bram_subsys_top; latency checks assume no back-pressure and a fixed three-clock pipeline
`timescale 1ns/1ps

module bram_subsys_assertions (
   input logic                mig_clk,
   input logic                rst_n_i,
   input logic                req_valid_i,
   input logic                resp_valid_i,
   input bram_pkg::mem_resp_t resp_i
);

   int fail_cnt = 0;   // failed assertions so far

   // response strobe mirrors the request strobe three edges later
   resp_latency_chk : assert property (
      @(posedge mig_clk) disable iff (!rst_n_i)
      resp_valid_i == $past(req_valid_i, 3)
   ) else begin
      $error("response strobe does not follow the request strobe by three cycles");
      fail_cnt++;
   end

   // quiet during reset and on the first edge after it
   resp_quiet_chk : assert property (
      @(posedge mig_clk)
      (!rst_n_i || $past(!rst_n_i)) |-> !resp_valid_i
   ) else begin
      $error("response strobe high during or right after reset");
      fail_cnt++;
   end

   // decode errors never carry data
   err_zero_chk : assert property (
      @(posedge mig_clk) disable iff (!rst_n_i)
      (resp_valid_i && resp_i.err) |-> (resp_i.rdata == '0)
   ) else begin
      $error("error response carries nonzero read data");
      fail_cnt++;
   end

endmodule

bind bram_subsys_top bram_subsys_assertions u_assertions (
   .mig_clk      ( mig_clk      ),
   .rst_n_i      ( rst_n_i      ),
   .req_valid_i  ( req_valid_i  ),
   .resp_valid_i ( resp_valid_o ),
   .resp_i       ( resp_o       )
);

/* verif/bram_subsys_tb.sv */
// directed tests with a line-array reference model; only lines that were written are ever read back
`timescale 1ns/1ps

module bram_subsys_tb;

   import bram_pkg::*;

   localparam int LATENCY      = 3;
   localparam int SEED_INIT    = 29916;
   localparam int RESET_CYCLES = 4;
   localparam int IDLE_CYCLES  = 6;
   localparam int WR_LINES     = 8;
   localparam int STRB_LINES   = 8;
   localparam int B2B_PAIRS    = 4;
   localparam int ERR_REQS     = 9;
   localparam int TAG_REQS     = 4;
   localparam int NUM_TESTS    = 6;
   localparam int TOTAL_REQS   = 2 * WR_LINES + 3 * STRB_LINES + 2 * B2B_PAIRS
                                 + ERR_REQS + TAG_REQS;
   // every test drains its pipeline once, plus slack
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + TOTAL_REQS
                                   + NUM_TESTS * (LATENCY + 2) + 20;

   logic      mig_clk;
   logic      rst_n_i;
   logic      req_valid;
   mem_req_t  req;
   logic      resp_valid_o;
   mem_resp_t resp_o;

   line_data_t model_mem [BRAM_LINES];
   mem_resp_t  exp_q [$];
   int         exp_cyc_q [$];
   int         cyc;
   int         err_cnt;
   int         tests_run;
   int         tests_failed;
   integer     seed;

   tb_clock_gen u_clock_gen (
      .mig_clk ( mig_clk ),
      .rst_n_o ( rst_n_i )
   );

   bram_subsys_top u_bram_subsys_top (
      .mig_clk      ( mig_clk      ),
      .rst_n_i      ( rst_n_i      ),
      .req_valid_i  ( req_valid    ),
      .req_i        ( req          ),
      .resp_valid_o ( resp_valid_o ),
      .resp_o       ( resp_o       )
   );

   function automatic addr_t line_addr(input int line);
      return addr_t'(line) << LINE_OFFSET;
   endfunction

   // depends on every address bit
   function automatic line_data_t line_pattern(input addr_t addr, input int salt);
      return {addr ^ 32'hc3c3_0f0f, ~addr, addr * 3 + salt, {addr[15:0], addr[31:16]} ^ salt};
   endfunction

   function automatic id_t make_id(input logic io, input int tag);
      return {io, tag[TAG_WIDTH-1:0]};
   endfunction

   // procedural check errors plus bound assertion failures
   function automatic int total_errors();
      return err_cnt + u_bram_subsys_top.u_assertions.fail_cnt;
   endfunction

   task automatic compare_field(input string name, input logic [LINE_DATA_WIDTH-1:0] got,
                                input logic [LINE_DATA_WIDTH-1:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // drive one request and predict its response
   task automatic send_req(input logic we, input id_t id, input addr_t addr,
                           input line_data_t wdata, input line_strb_t strb);
      mem_resp_t exp;
      logic      hit;
      line_idx_t line;
      @(negedge mig_clk);
      req_valid = 1'b1;
      req.we    = we;
      req.id    = id;
      req.addr  = addr;
      req.wdata = wdata;
      req.strb  = strb;
      hit  = (addr[ADDR_WIDTH-1:BRAM_ADDR_WIDTH] == '0);   // 64 KB window at zero
      line = addr[BRAM_ADDR_WIDTH-1:LINE_OFFSET];
      exp.we    = we;
      exp.id    = id;
      exp.err   = !hit;
      exp.rdata = '0;
      if (hit && we) begin
         for (int b = 0; b < LINE_DATA_WIDTH / 8; b++) begin
            if (strb[b]) begin
               model_mem[line][b*8 +: 8] = wdata[b*8 +: 8];
            end
         end
      end else if (hit) begin
         exp.rdata = model_mem[line];
      end
      exp_q.push_back(exp);
      exp_cyc_q.push_back(cyc + LATENCY);
   endtask

   // drop the strobe, then wait until every response is back
   task automatic drain_responses();
      @(negedge mig_clk);
      req_valid = 1'b0;
      req       = '0;
      while (exp_q.size() != 0) begin
         @(negedge mig_clk);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (total_errors() == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, total_errors() - errs_before);
         tests_failed++;
      end
   endtask

   task automatic check_reset_quiet();
      int errs;
      errs = total_errors();
      while (rst_n_i !== 1'b1) begin
         @(negedge mig_clk);
         compare_field("resp_valid_o", resp_valid_o, 1'b0);
      end
      repeat (IDLE_CYCLES) begin
         @(negedge mig_clk);
         compare_field("resp_valid_o", resp_valid_o, 1'b0);
      end
      report_test("reset", errs);
   endtask

   task automatic full_line_write_read();
      int    errs;
      addr_t a;
      errs = total_errors();
      for (int i = 0; i < WR_LINES; i++) begin
         a = line_addr(i * 37 + 3);
         send_req(1'b1, make_id(1'b0, i), a, line_pattern(a, i), '1);
      end
      for (int i = 0; i < WR_LINES; i++) begin
         a = line_addr(i * 37 + 3);
         send_req(1'b0, make_id(1'b0, i + 8), a, '0, '0);
      end
      drain_responses();
      report_test("full line write and read", errs);
   endtask

   task automatic byte_strobe_merge();
      int         errs;
      addr_t      a;
      line_strb_t strb;
      line_data_t data;
      errs = total_errors();
      for (int i = 0; i < STRB_LINES; i++) begin
         a = line_addr(64 + i * 5);
         send_req(1'b1, make_id(1'b1, i), a, line_pattern(a, 100 + i), '1);
      end
      for (int i = 0; i < STRB_LINES; i++) begin
         a    = line_addr(64 + i * 5);
         strb = line_strb_t'($random(seed));
         data = {$random(seed), $random(seed), $random(seed), $random(seed)};
         send_req(1'b1, make_id(1'b0, i), a, data, strb);
      end
      for (int i = 0; i < STRB_LINES; i++) begin
         a = line_addr(64 + i * 5);
         send_req(1'b0, make_id(1'b1, i + 16), a, '0, '0);
      end
      drain_responses();
      report_test("byte strobes", errs);
   endtask

   task automatic back_to_back_stream();
      int    errs;
      addr_t a;
      errs = total_errors();
      // write then read of the same line on consecutive cycles
      for (int i = 0; i < B2B_PAIRS; i++) begin
         a = line_addr(200 + i);
         send_req(1'b1, make_id(1'b0, 2 * i), a, line_pattern(a, 7 + i), '1);
         send_req(1'b0, make_id(1'b0, 2 * i + 1), a, '0, '0);
      end
      drain_responses();
      report_test("back to back", errs);
   endtask

   task automatic decode_error_access();
      int errs;
      errs = total_errors();
      send_req(1'b1, make_id(1'b0, 1), line_addr(0), line_pattern(line_addr(0), 3), '1);
      send_req(1'b1, make_id(1'b0, 2), line_addr(1), line_pattern(line_addr(1), 4), '1);
      send_req(1'b0, make_id(1'b0, 3), 32'h0001_0000, '0, '0);
      send_req(1'b0, make_id(1'b1, 4), 32'h4000_0000, '0, '0);
      send_req(1'b0, make_id(1'b1, 5), 32'h8000_0000, '0, '0);
      // these alias lines 0 and 1 in the low address bits
      send_req(1'b1, make_id(1'b0, 6), 32'h0001_0000, {4{32'hdead_beef}}, '1);
      send_req(1'b1, make_id(1'b1, 7), 32'h4000_0010, {4{32'hfeed_f00d}}, '1);
      send_req(1'b0, make_id(1'b0, 8), line_addr(0), '0, '0);
      send_req(1'b0, make_id(1'b0, 9), line_addr(1), '0, '0);
      drain_responses();
      report_test("decode errors", errs);
   endtask

   task automatic tag_passthrough();
      int errs;
      errs = total_errors();
      send_req(1'b1, 6'h2a, line_addr(300), line_pattern(line_addr(300), 9), '1);
      send_req(1'b0, 6'h15, line_addr(300), '0, '0);
      send_req(1'b0, 6'h3f, 32'h8000_0040, '0, '0);
      send_req(1'b0, 6'h00, line_addr(300), '0, '0);
      drain_responses();
      report_test("tag passthrough", errs);
   endtask

   // outputs settle after the rising edge, so they are read on the falling one
   always @(negedge mig_clk) begin : check_responses
      mem_resp_t exp;
      int        exp_cyc;
      if (resp_valid_o === 1'b1) begin
         assert (exp_q.size() != 0) else begin
            $display("%0t: response strobe arrived with no request outstanding", $time);
            err_cnt++;
         end
         if (exp_q.size() != 0) begin
            exp     = exp_q.pop_front();
            exp_cyc = exp_cyc_q.pop_front();
            compare_field("response cycle", cyc, exp_cyc);
            compare_field("resp_o.we", resp_o.we, exp.we);
            compare_field("resp_o.id", resp_o.id, exp.id);
            compare_field("resp_o.err", resp_o.err, exp.err);
            compare_field("resp_o.rdata", resp_o.rdata, exp.rdata);
         end
      end
   end

   always @(posedge mig_clk) begin
      cyc++;
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      req_valid    = 1'b0;
      req          = '0;
      cyc          = 0;
      err_cnt      = 0;
      tests_run    = 0;
      tests_failed = 0;
      seed         = SEED_INIT;
      check_reset_quiet();
      full_line_write_read();
      byte_strobe_merge();
      back_to_back_stream();
      decode_error_access();
      tag_passthrough();
      $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, err_cnt, u_bram_subsys_top.u_assertions.fail_cnt);
      if (total_errors() == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* sim.f */
rtl/bram_pkg.sv
rtl/mem_region_decode.sv
rtl/bram_line_store.sv
rtl/mem_resp_stage.sv
rtl/bram_subsys_top.sv
verif/tb_clock_gen.sv
verif/bram_subsys_assertions.sv
verif/bram_subsys_tb.sv

/* Bender.yml */
# block RAM subsystem behind the memory crossbar

package:
  name: bram_subsys

sources:
  # design, package first
  - files:
      - rtl/bram_pkg.sv
      - rtl/mem_region_decode.sv
      - rtl/bram_line_store.sv
      - rtl/mem_resp_stage.sv
      - rtl/bram_subsys_top.sv

  # simulation only, top module bram_subsys_tb
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/bram_subsys_assertions.sv
      - verif/bram_subsys_tb.sv
